//--- Bender.yml
package:
  name: rv32i_backend

sources:
  - target: rtl
    files:
      - rtl/rv32i_types.sv
      - rtl/rv32i_packet.sv
      - rtl/mem_stage.sv
      - rtl/data_ram.sv
      - rtl/wb_stage.sv
      - rtl/regfile.sv
      - rtl/rv32i_backend_top.sv
  - target: bench
    files:
      - bench/clk_gen.sv
      - bench/backend_tb.sv

//--- bench/backend_tb.sv
module backend_tb #(
    parameter int RAM_DEPTH  = 16,
    parameter int NUM_RANDOM = 200
);

    timeunit 1ns;
    timeprecision 100ps;

    import rv32i_types::*;
    import rv32i_packet::*;

    localparam int GAP            = 4;
    localparam int TEST_CYCLES    = 3 + 32 + RAM_DEPTH + 30 + NUM_RANDOM + 5 * GAP;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    typedef struct packed {
        logic      en;
        rv32i_reg  rd;
        rv32i_word exp;
        rv32i_reg  rd2;
        rv32i_word exp2;
    } check_t;

    logic          clk;
    logic          rst;
    rv32i_packet_t ex_pkt;
    rv32i_reg      rs1 = '0;
    rv32i_reg      rs2 = '0;
    rv32i_word     rs1_out;
    rv32i_word     rs2_out;
    check_t        issue_chk = '0;  // set along with each driven packet
    check_t        mid_chk   = '0;
    check_t        chk       = '0;  // matches what rs1 and rs2 currently select
    rv32i_word     model_reg [32];
    logic [7:0]    model_mem [4 * RAM_DEPTH];
    integer        seed = 32'hbe33eae7;
    int            cycles = 0;
    int            err_count = 0;
    int            err_base = 0;
    int            check_count = 0;
    int            tests_passed = 0;
    int            tests_failed = 0;

    clk_gen #(.PERIOD (100)) u_clk_gen (.clk (clk), .rst (rst));

    rv32i_backend_top #(.RAM_DEPTH (RAM_DEPTH)) UUT (
        .clk     (clk),
        .rst     (rst),
        .ex_pkt  (ex_pkt),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_out (rs1_out),
        .rs2_out (rs2_out)
    );

    // a register write lands one edge after the memory stage registers the packet
    always @(posedge clk) begin
        mid_chk <= issue_chk;
        chk     <= mid_chk;
        rs1     <= mid_chk.rd;
        rs2     <= mid_chk.rd2;
        if (chk.en)
            check_count <= check_count + 1;
    end

    rs1_check: assert property (@(posedge clk) chk.en |-> rs1_out == chk.exp)
        else begin
            $display("ERR rs1_out x%0d: expected %h, got %h",
                     $sampled(chk.rd), $sampled(chk.exp), $sampled(rs1_out));
            err_count++;
        end

    rs2_check: assert property (@(posedge clk) chk.en |-> rs2_out == chk.exp2)
        else begin
            $display("ERR rs2_out x%0d: expected %h, got %h",
                     $sampled(chk.rd2), $sampled(chk.exp2), $sampled(rs2_out));
            err_count++;
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic rv32i_word next_rand();
        return $random(seed);
    endfunction

    // little-endian read of n bytes from the model memory
    function automatic rv32i_word read_model(rv32i_word addr, int n);
        rv32i_word v;
        v = '0;
        for (int i = n - 1; i >= 0; i--)
            v = (v << 8) | model_mem[addr + i];
        return v;
    endfunction

    function automatic rv32i_word wb_value(rv32i_packet_t p);
        rv32i_word a;
        rv32i_word v;
        a = p.data.alu_out;
        case (p.ctrl.regfilemux_sel)
            rfmux_br_en:    v = {31'b0, p.data.br_en};
            rfmux_u_imm:    v = p.inst.u_imm;
            rfmux_pc_plus4: v = p.data.pc + 32'd4;
            rfmux_lw:       v = read_model(a & ~32'd3, 4);
            rfmux_lbu:      v = read_model(a, 1);
            rfmux_lhu:      v = read_model(a & ~32'd1, 2);
            rfmux_lb: begin
                v = read_model(a, 1);
                v = {{24{v[7]}}, v[7:0]};
            end
            rfmux_lh: begin
                v = read_model(a & ~32'd1, 2);
                v = {{16{v[15]}}, v[15:0]};
            end
            default:        v = a;
        endcase
        return v;
    endfunction

    // expected contents of register r on the first port and of its complement on the second
    function automatic check_t expect_regs(rv32i_reg r);
        rv32i_reg r2;
        r2 = ~r;
        return check_t'{1'b1, r, model_reg[r], r2, model_reg[r2]};
    endfunction

    function automatic rv32i_packet_t make_pkt(rv32i_reg rd, regfilemux_sel_t sel,
                                               rv32i_word alu);
        rv32i_packet_t p;
        p                     = '0;
        p.valid               = 1'b1;
        p.inst.rd             = rd;
        p.inst.width          = mem_w;
        p.ctrl.regfilemux_sel = sel;
        p.ctrl.load_regfile   = 1'b1;
        p.data.alu_out        = alu;
        return p;
    endfunction

    function automatic rv32i_packet_t mem_pkt(rv32i_reg rd, regfilemux_sel_t sel,
                                              mem_width_t width, rv32i_word addr,
                                              logic store, rv32i_word data);
        rv32i_packet_t p;
        p                   = make_pkt(rd, sel, addr);
        p.inst.width        = width;
        p.ctrl.mem_write    = store;
        p.ctrl.mem_read     = !store;
        p.ctrl.load_regfile = !store;
        p.data.rs2_out      = data;
        return p;
    endfunction

    function automatic rv32i_packet_t random_pkt();
        rv32i_packet_t p;
        rv32i_word     r;
        rv32i_word     a;
        r = next_rand();
        a = next_rand() % (4 * RAM_DEPTH);
        p = make_pkt(r[4:0], rfmux_alu_out, next_rand());
        case (r[11:10])
            2'd0: begin
                p.ctrl.regfilemux_sel = regfilemux_sel_t'(r[13:12] == 2'd3 ? 4'd4 : r[13:12]);
            end
            2'd1: begin
                if (r[13:12] == 2'd0)
                    p = mem_pkt(r[4:0], rfmux_alu_out, mem_b, a, 1'b1, next_rand());
                else if (r[13:12] == 2'd1)
                    p = mem_pkt(r[4:0], rfmux_alu_out, mem_h, a & ~32'd1, 1'b1, next_rand());
                else
                    p = mem_pkt(r[4:0], rfmux_alu_out, mem_w, a & ~32'd3, 1'b1, next_rand());
            end
            default: begin
                case (r[14:12])
                    3'd0:    p = mem_pkt(r[4:0], rfmux_lb, mem_b, a, 1'b0, '0);
                    3'd1:    p = mem_pkt(r[4:0], rfmux_lbu, mem_bu, a, 1'b0, '0);
                    3'd2:    p = mem_pkt(r[4:0], rfmux_lh, mem_h, a & ~32'd1, 1'b0, '0);
                    3'd3:    p = mem_pkt(r[4:0], rfmux_lhu, mem_hu, a & ~32'd1, 1'b0, '0);
                    default: p = mem_pkt(r[4:0], rfmux_lw, mem_w, a & ~32'd3, 1'b0, '0);
                endcase
            end
        endcase
        p.valid             = r[7:5] != 3'd0;  // one packet in eight is a bubble
        p.ctrl.load_regfile = r[8];
        p.data.br_en        = r[9];
        p.inst.u_imm        = next_rand();
        p.data.pc           = next_rand();
        return p;
    endfunction

    // updates the model at issue time, then drives the packet and its check
    task automatic issue(rv32i_packet_t p);
        rv32i_word v;
        rv32i_word base;
        int        n;
        v = wb_value(p);
        if (p.valid && p.ctrl.mem_write) begin
            n    = (p.inst.width inside {mem_b, mem_bu}) ? 1 :
                   (p.inst.width inside {mem_h, mem_hu}) ? 2 : 4;
            base = p.data.alu_out & ~(n - 1);
            for (int i = 0; i < n; i++)
                model_mem[base + i] = p.data.rs2_out[8*i +: 8];
        end
        if (p.valid && p.ctrl.load_regfile && p.inst.rd != 5'd0)
            model_reg[p.inst.rd] = v;
        @(posedge clk);
        ex_pkt    <= p;
        issue_chk <= expect_regs(p.inst.rd);
    endtask

    task automatic check_reg(rv32i_reg r);
        @(posedge clk);
        ex_pkt.valid <= 1'b0;
        issue_chk    <= expect_regs(r);
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            ex_pkt.valid <= 1'b0;
            issue_chk    <= '0;
        end
    endtask

    task automatic end_test(string name);
        idle(GAP);
        if (err_count == err_base) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, err_count - err_base);
        end
        err_base = err_count;
    endtask

    initial begin
        rv32i_packet_t p;
        rv32i_word     a;
        rv32i_word     d;
        ex_pkt = '0;
        for (int i = 0; i < 32; i++)
            model_reg[i] = '0;
        while (rst !== 1'b0)
            @(posedge clk);

        for (int i = 0; i < 32; i++)
            check_reg(i[4:0]);
        end_test("after reset");

        issue(make_pkt(5'd5, rfmux_alu_out, next_rand()));
        p = make_pkt(5'd6, rfmux_br_en, next_rand());
        p.data.br_en = 1'b1;
        issue(p);
        issue(make_pkt(5'd7, rfmux_alu_out, next_rand()));
        p = make_pkt(5'd7, rfmux_br_en, next_rand());  // clears the value just written
        issue(p);
        p = make_pkt(5'd8, rfmux_u_imm, next_rand());
        p.inst.u_imm = next_rand() & 32'hffff_f000;
        issue(p);
        p = make_pkt(5'd9, rfmux_pc_plus4, next_rand());
        p.data.pc = next_rand() & ~32'd3;
        issue(p);
        issue(make_pkt(5'd0, rfmux_alu_out, 32'hdead_beef));
        end_test("non-memory sources");

        // every word gets a value that depends on its whole address
        for (int w = 0; w < RAM_DEPTH; w++) begin
            a = 4 * w;
            issue(mem_pkt(5'd0, rfmux_alu_out, mem_w, a, 1'b1, (a * 32'h9e37_79b1) ^ 32'h5a5a_a5a5));
        end
        a = 4 * (next_rand() % RAM_DEPTH);
        issue(mem_pkt(5'd0, rfmux_alu_out, mem_w, a, 1'b1, next_rand()));
        issue(mem_pkt(5'd10, rfmux_lw, mem_w, a, 1'b0, '0));
        a = 4 * (next_rand() % RAM_DEPTH);
        issue(mem_pkt(5'd0, rfmux_alu_out, mem_w, a, 1'b1, next_rand()));
        idle(3);
        issue(mem_pkt(5'd11, rfmux_lw, mem_w, a, 1'b0, '0));
        end_test("word path");

        for (int lane = 0; lane < 4; lane++) begin
            a    = 32'd20 + lane;
            d    = next_rand();
            d[7] = lane[0];  // both signs of the byte
            issue(mem_pkt(5'd0, rfmux_alu_out, mem_b, a, 1'b1, d));
            issue(mem_pkt(5'd12, rfmux_lb, mem_b, a, 1'b0, '0));
            issue(mem_pkt(5'd13, rfmux_lbu, mem_bu, a, 1'b0, '0));
        end
        for (int h = 0; h < 2; h++) begin
            a     = 32'd24 + 2 * h;
            d     = next_rand();
            d[15] = h[0];
            issue(mem_pkt(5'd0, rfmux_alu_out, mem_h, a, 1'b1, d));
            issue(mem_pkt(5'd14, rfmux_lh, mem_h, a, 1'b0, '0));
            issue(mem_pkt(5'd15, rfmux_lhu, mem_hu, a, 1'b0, '0));
        end
        end_test("sub-word loads");

        repeat (NUM_RANDOM)
            issue(random_pkt());
        end_test("random mix");

        $display("tests passed: %0d, tests failed: %0d, register checks: %0d",
                 tests_passed, tests_failed, check_count);
        if (tests_failed == 0 && err_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- bench/clk_gen.sv
module clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;  // released after the second rising edge
    end

endmodule

//--- rtl/data_ram.sv
module data_ram #(
    parameter int RAM_DEPTH = 256
) (
    input  logic                   clk,
    input  rv32i_types::rv32i_word addr,
    input  rv32i_types::rv32i_word wdata,
    input  rv32i_types::byte_en_t  byte_enable,
    input  logic                   read,
    input  logic                   write,
    output rv32i_types::rv32i_word rdata
);

    import rv32i_types::*;

    localparam int ADDR_W = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;

    rv32i_word          mem [RAM_DEPTH];
    logic [ADDR_W-1:0]  idx;

    assign idx = addr[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (write) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_enable[i])
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
        if (read)
            rdata <= mem[idx];  // old contents on a same-edge write
    end

endmodule

//--- rtl/mem_stage.sv
module mem_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  rv32i_packet::rv32i_packet_t ex_pkt,
    output rv32i_types::rv32i_word      mem_addr,
    output rv32i_types::rv32i_word      mem_wdata,
    output rv32i_types::byte_en_t       mem_byte_enable,
    output logic                        mem_read,
    output logic                        mem_write,
    input  rv32i_types::rv32i_word      mem_rdata,
    output rv32i_packet::rv32i_packet_t wb_pkt
);

    import rv32i_types::*;
    import rv32i_packet::*;

    logic [1:0]    offset;
    byte_en_t      byte_en;
    rv32i_word     store_data;
    rv32i_packet_t next_pkt;
    rv32i_packet_t wb_q;

    assign offset = ex_pkt.data.alu_out[1:0];

    // lane selection and store alignment by access width
    always_comb begin
        case (ex_pkt.inst.width)
            mem_b, mem_bu: begin
                byte_en    = 4'b0001 << offset;
                store_data = ex_pkt.data.rs2_out << {offset, 3'b000};
            end
            mem_h, mem_hu: begin
                byte_en    = offset[1] ? 4'b1100 : 4'b0011;
                store_data = ex_pkt.data.rs2_out << {offset[1], 4'b0000};
            end
            default: begin
                byte_en    = 4'b1111;
                store_data = ex_pkt.data.rs2_out;
            end
        endcase
    end

    assign mem_addr        = {2'b00, ex_pkt.data.alu_out[31:2]};  // word index
    assign mem_wdata       = store_data;
    assign mem_byte_enable = byte_en;
    assign mem_read        = ex_pkt.valid & ex_pkt.ctrl.mem_read;
    assign mem_write       = ex_pkt.valid & ex_pkt.ctrl.mem_write;

    always_comb begin
        next_pkt                           = ex_pkt;
        next_pkt.data.mdrreg_out           = '0;
        next_pkt.ctrl.data_mem_byte_enable = byte_en;
    end

    always_ff @(posedge clk) begin
        wb_q <= next_pkt;
        if (rst)
            wb_q.valid <= 1'b0;
    end

    // the memory's output register acts as the MDR, so its word is merged
    // into the packet after the same edge that captured the rest
    always_comb begin
        wb_pkt                 = wb_q;
        wb_pkt.data.mdrreg_out = mem_rdata;
    end

endmodule

//--- rtl/regfile.sv
module regfile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,
    input  rv32i_types::rv32i_reg  dest,
    input  rv32i_types::rv32i_word in,
    input  rv32i_types::rv32i_reg  src_a,
    input  rv32i_types::rv32i_reg  src_b,
    output rv32i_types::rv32i_word reg_a,
    output rv32i_types::rv32i_word reg_b
);

    import rv32i_types::*;

    rv32i_word regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (load && dest != 5'd0) begin
            regs[dest] <= in;  // x0 never leaves its reset value
        end
    end

    // no bypass, a write shows up on the ports after its edge
    assign reg_a = regs[src_a];
    assign reg_b = regs[src_b];

endmodule

//--- rtl/rv32i_backend_top.sv
module rv32i_backend_top #(
    parameter int RAM_DEPTH = 256
) (
    input  logic                        clk,
    input  logic                        rst,
    input  rv32i_packet::rv32i_packet_t ex_pkt,
    input  rv32i_types::rv32i_reg       rs1,
    input  rv32i_types::rv32i_reg       rs2,
    output rv32i_types::rv32i_word      rs1_out,
    output rv32i_types::rv32i_word      rs2_out
);

    import rv32i_types::*;
    import rv32i_packet::*;

    rv32i_word     mem_addr;
    rv32i_word     mem_wdata;
    rv32i_word     mem_rdata;
    byte_en_t      mem_byte_enable;
    logic          mem_read;
    logic          mem_write;
    rv32i_packet_t wb_pkt;
    rv32i_word     regfile_in;
    rv32i_reg      dest;
    logic          load_regfile;

    mem_stage u_mem_stage (
        .clk             (clk),
        .rst             (rst),
        .ex_pkt          (ex_pkt),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_rdata       (mem_rdata),
        .wb_pkt          (wb_pkt)
    );

    data_ram #(
        .RAM_DEPTH (RAM_DEPTH)
    ) u_data_ram (
        .clk         (clk),
        .addr        (mem_addr),
        .wdata       (mem_wdata),
        .byte_enable (mem_byte_enable),
        .read        (mem_read),
        .write       (mem_write),
        .rdata       (mem_rdata)
    );

    wb_stage u_wb_stage (
        .wb_pkt       (wb_pkt),
        .regfile_in   (regfile_in),
        .dest         (dest),
        .load_regfile (load_regfile)
    );

    regfile u_regfile (
        .clk   (clk),
        .rst   (rst),
        .load  (load_regfile),
        .dest  (dest),
        .in    (regfile_in),
        .src_a (rs1),
        .src_b (rs2),
        .reg_a (rs1_out),
        .reg_b (rs2_out)
    );

endmodule

//--- rtl/rv32i_packet.sv
package rv32i_packet;

    import rv32i_types::*;

    // decoded fields still needed past execute
    typedef struct packed {
        rv32i_reg   rd;
        mem_width_t width;
        rv32i_word  u_imm;
    } rv32i_inst_t;

    typedef struct packed {
        rv32i_word alu_out;    // also the data memory address
        logic      br_en;
        rv32i_word pc;
        rv32i_word rs2_out;    // store data
        rv32i_word mdrreg_out;
    } rv32i_data_t;

    typedef struct packed {
        regfilemux_sel_t regfilemux_sel;
        logic            load_regfile;
        logic            mem_read;
        logic            mem_write;
        byte_en_t        data_mem_byte_enable;
    } rv32i_ctrl_packet_t;

    // one instruction in flight
    typedef struct packed {
        logic               valid;
        rv32i_inst_t        inst;
        rv32i_data_t        data;
        rv32i_ctrl_packet_t ctrl;
    } rv32i_packet_t;

endpackage

//--- rtl/rv32i_types.sv
package rv32i_types;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;
    typedef logic [3:0]  byte_en_t;

    // funct3 encodings of the load and store widths
    typedef enum logic [2:0] {
        mem_b  = 3'b000,
        mem_h  = 3'b001,
        mem_w  = 3'b010,
        mem_bu = 3'b100,
        mem_hu = 3'b101
    } mem_width_t;

    // sources for the value written back to rd
    typedef enum logic [3:0] {
        rfmux_alu_out  = 4'd0,
        rfmux_br_en    = 4'd1,
        rfmux_u_imm    = 4'd2,
        rfmux_lw       = 4'd3,
        rfmux_pc_plus4 = 4'd4,
        rfmux_lb       = 4'd5,
        rfmux_lbu      = 4'd6,
        rfmux_lh       = 4'd7,
        rfmux_lhu      = 4'd8
    } regfilemux_sel_t;

endpackage

//--- rtl/wb_stage.sv
module wb_stage (
    input  rv32i_packet::rv32i_packet_t wb_pkt,
    output rv32i_types::rv32i_word      regfile_in,
    output rv32i_types::rv32i_reg       dest,
    output logic                        load_regfile
);

    import rv32i_types::*;

    rv32i_word alu_out;
    rv32i_word br_en;
    rv32i_word u_imm;
    rv32i_word mdr;
    rv32i_word pc;
    byte_en_t  be;

    assign alu_out = wb_pkt.data.alu_out;
    assign br_en   = {31'b0, wb_pkt.data.br_en};
    assign u_imm   = wb_pkt.inst.u_imm;
    assign mdr     = wb_pkt.data.mdrreg_out;
    assign pc      = wb_pkt.data.pc;
    assign be      = wb_pkt.ctrl.data_mem_byte_enable;

    assign dest         = wb_pkt.inst.rd;
    assign load_regfile = wb_pkt.valid & wb_pkt.ctrl.load_regfile;

    always_comb begin
        regfile_in = alu_out;  // also the fallback for an unknown select
        case (wb_pkt.ctrl.regfilemux_sel)
            rfmux_alu_out:  regfile_in = alu_out;
            rfmux_br_en:    regfile_in = br_en;
            rfmux_u_imm:    regfile_in = u_imm;
            rfmux_lw:       regfile_in = mdr;
            rfmux_pc_plus4: regfile_in = pc + 32'd4;
            rfmux_lb, rfmux_lbu: begin
                case (be)
                    4'b0001: regfile_in = {24'b0, mdr[7:0]};
                    4'b0010: regfile_in = {24'b0, mdr[15:8]};
                    4'b0100: regfile_in = {24'b0, mdr[23:16]};
                    4'b1000: regfile_in = {24'b0, mdr[31:24]};
                    default: regfile_in = mdr;
                endcase
                // sign extension only when a single lane was picked
                if (wb_pkt.ctrl.regfilemux_sel == rfmux_lb && $onehot(be))
                    regfile_in[31:8] = {24{regfile_in[7]}};
            end
            rfmux_lh, rfmux_lhu: begin
                case (be)
                    4'b0011: regfile_in = {16'b0, mdr[15:0]};
                    4'b1100: regfile_in = {16'b0, mdr[31:16]};
                    default: regfile_in = mdr;
                endcase
                if (wb_pkt.ctrl.regfilemux_sel == rfmux_lh && (be == 4'b0011 || be == 4'b1100))
                    regfile_in[31:16] = {16{regfile_in[15]}};
            end
            default: regfile_in = alu_out;
        endcase
    end

endmodule

//--- sim.f
rtl/rv32i_types.sv
rtl/rv32i_packet.sv
rtl/mem_stage.sv
rtl/data_ram.sv
rtl/wb_stage.sv
rtl/regfile.sv
rtl/rv32i_backend_top.sv
bench/clk_gen.sv
bench/backend_tb.sv
